// File: common/lsu_pkg.sv
//********************
// Shared types and constants of the load/store unit
// DCCM is a 1 KB window at LSU_DCCM_BASE, word organized
// Store buffer depth must stay a power of two, pointers wrap freely
// Anything outside the DCCM window faults, there is no bus path
//********************
`default_nettype none

package lsu_pkg;

   //********************
   // Address map and sizes
   localparam logic [31:0] LSU_DCCM_BASE      = 32'hf004_0000;
   localparam int          LSU_DCCM_ADDR_BITS = 10;          // Byte address bits, 1 KB
   localparam int          LSU_DCCM_WORDS     = 256;
   localparam int          LSU_STBUF_DEPTH    = 4;
   localparam int          LSU_STBUF_PTR_BITS = 2;

   //********************
   // Encodings
   typedef enum logic {
      LSU_LOAD  = 1'b0,
      LSU_STORE = 1'b1
   } lsu_op_e;

   typedef enum logic [1:0] {
      LSU_BYTE = 2'b00,
      LSU_HALF = 2'b01,
      LSU_WORD = 2'b10                                       // 2'b11 treated as word
   } lsu_size_e;

   typedef enum logic {
      LSU_CAUSE_MISALIGN = 1'b0,
      LSU_CAUSE_ACCESS   = 1'b1                              // Outside DCCM window
   } lsu_cause_e;

   // Decoder packet
   typedef struct packed {
      logic      valid;
      lsu_op_e   op;
      lsu_size_e size;
      logic      unsign;                                     // Zero extend on load
   } lsu_pkt_t;

   // One record per pipe stage
   typedef struct packed {
      lsu_pkt_t    pkt;
      logic [31:0] addr;
      logic [31:0] data;                                     // Store data, raw from rs2
      logic        fault;
      lsu_cause_e  cause;
   } lsu_stage_t;

   typedef struct packed {
      logic        exc_valid;
      logic        is_store;
      lsu_cause_e  cause;
      logic [31:0] addr;
   } lsu_error_pkt_t;

   // Store buffer entry, data already placed on its byte lanes
   typedef struct packed {
      logic [LSU_DCCM_ADDR_BITS-3:0] index;
      logic [3:0]                    byteen;
      logic [31:0]                   data;
   } lsu_stbuf_entry_t;

   typedef struct packed {
      logic                          wren;
      logic [LSU_DCCM_ADDR_BITS-3:0] index;
      logic [3:0]                    byteen;
      logic [31:0]                   data;
   } lsu_dccm_wr_t;

endpackage

`default_nettype wire

// File: hw/lsu_lsc_ctl.sv
//********************
// Address generation, fault checks and the dc1-dc3 pipe
// One instruction per cycle, no stall of its own
// Flush kills dc1-dc3 only, the d stage instruction still enters
//********************
`default_nettype none

module lsu_lsc_ctl (
   input  logic                clk,
   input  logic                reset,
   input  lsu_pkg::lsu_pkt_t   lsu_p,
   input  logic [31:0]         rs1,
   input  logic [11:0]         offset,
   input  logic [31:0]         store_data,
   input  logic                flush_dc3,
   output lsu_pkg::lsu_stage_t stage_dc1,
   output lsu_pkg::lsu_stage_t stage_dc2,
   output lsu_pkg::lsu_stage_t stage_dc3
);

   lsu_pkg::lsu_stage_t stage_d;
   logic [31:0]         addr_d;
   logic                in_dccm_d;
   logic                misalign_d;

   //********************
   // D stage
   assign addr_d = rs1 + {{20{offset[11]}}, offset};          // Sign extended offset

   // Upper bits must hit the DCCM window
   assign in_dccm_d = (addr_d[31:lsu_pkg::LSU_DCCM_ADDR_BITS] ==
                       lsu_pkg::LSU_DCCM_BASE[31:lsu_pkg::LSU_DCCM_ADDR_BITS]);

   always_comb begin
      unique case (lsu_p.size)
         lsu_pkg::LSU_BYTE: misalign_d = 1'b0;
         lsu_pkg::LSU_HALF: misalign_d = addr_d[0];
         default:           misalign_d = |addr_d[1:0];
      endcase
   end

   always_comb begin
      stage_d.pkt   = lsu_p;
      stage_d.addr  = addr_d;
      stage_d.data  = store_data;
      stage_d.fault = misalign_d | ~in_dccm_d;
      // Misaligned reported ahead of access fault
      stage_d.cause = misalign_d ? lsu_pkg::LSU_CAUSE_MISALIGN : lsu_pkg::LSU_CAUSE_ACCESS;
   end

   //********************
   // Pipe registers, only the valids are reset
   always_ff @(posedge clk) begin
      stage_dc1 <= stage_d;
      stage_dc2 <= stage_dc1;
      stage_dc3 <= stage_dc2;
      stage_dc2.pkt.valid <= stage_dc1.pkt.valid & ~flush_dc3;   // Killed before advancing
      stage_dc3.pkt.valid <= stage_dc2.pkt.valid & ~flush_dc3;
      if (reset) begin
         stage_dc1.pkt.valid <= 1'b0;
         stage_dc2.pkt.valid <= 1'b0;
         stage_dc3.pkt.valid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: stbuf/lsu_stbuf.sv
//********************
// Store buffer, circular FIFO of byte enabled word writes
// Commits the dc3 store, drains one entry per cycle to the DCCM
// Overflow is prevented only by the decoder honoring the stall
// Forward result for a dc2 load is presented in dc3
//********************
`default_nettype none

module lsu_stbuf (
   input  logic                  clk,
   input  logic                  reset,
   input  lsu_pkg::lsu_stage_t   stage_dc1,
   input  lsu_pkg::lsu_stage_t   stage_dc2,
   input  lsu_pkg::lsu_stage_t   stage_dc3,
   input  logic                  flush_dc3,
   output logic [31:0]           fwd_data_dc3,
   output logic [3:0]            fwd_byteen_dc3,
   output lsu_pkg::lsu_dccm_wr_t dccm_wr,
   output logic                  stbuf_empty,
   output logic                  lsu_store_stall_any
);

   localparam int PB = lsu_pkg::LSU_STBUF_PTR_BITS;
   localparam int CW = PB + 2;                                // Occupancy plus in-flight

   lsu_pkg::lsu_stbuf_entry_t entries [lsu_pkg::LSU_STBUF_DEPTH];
   lsu_pkg::lsu_stbuf_entry_t entry_dc3;
   logic [PB-1:0]             wr_ptr;
   logic [PB-1:0]             rd_ptr;
   logic [PB:0]               count;
   logic [PB-1:0]             fwd_slot;
   logic                      commit_dc3;
   logic                      drain;
   logic                      ld_cmp_dc2;
   logic [31:0]               fwd_data_dc2;
   logic [3:0]                fwd_byteen_dc2;
   logic [CW-1:0]             st_inflight;

   // Place store data on its byte lanes
   function automatic lsu_pkg::lsu_stbuf_entry_t make_entry(input lsu_pkg::lsu_stage_t st);
      lsu_pkg::lsu_stbuf_entry_t e;
      e.index = st.addr[lsu_pkg::LSU_DCCM_ADDR_BITS-1:2];
      unique case (st.pkt.size)
         lsu_pkg::LSU_BYTE: begin
            e.byteen = 4'b0001 << st.addr[1:0];
            e.data   = {4{st.data[7:0]}};
         end
         lsu_pkg::LSU_HALF: begin
            e.byteen = 4'b0011 << st.addr[1:0];
            e.data   = {2{st.data[15:0]}};
         end
         default: begin
            e.byteen = 4'b1111;
            e.data   = st.data;
         end
      endcase
      return e;
   endfunction

   assign entry_dc3  = make_entry(stage_dc3);
   assign commit_dc3 = stage_dc3.pkt.valid & (stage_dc3.pkt.op == lsu_pkg::LSU_STORE) &
                       ~stage_dc3.fault & ~flush_dc3;
   assign drain      = (count != '0);                         // Oldest leaves every cycle
   assign stbuf_empty = (count == '0);

   //********************
   // FIFO state
   always_ff @(posedge clk) begin
      if (commit_dc3) begin
         entries[wr_ptr] <= entry_dc3;                         // Payload, no reset
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         wr_ptr <= wr_ptr + PB'(commit_dc3);
         rd_ptr <= rd_ptr + PB'(drain);
         count  <= count + (PB+1)'(commit_dc3) - (PB+1)'(drain);
      end
   end

   always_comb begin
      dccm_wr.wren   = drain;
      dccm_wr.index  = entries[rd_ptr].index;
      dccm_wr.byteen = entries[rd_ptr].byteen;
      dccm_wr.data   = entries[rd_ptr].data;
   end

   //********************
   // Forward compare in dc2, oldest first so younger bytes overwrite
   assign ld_cmp_dc2 = stage_dc2.pkt.valid & (stage_dc2.pkt.op == lsu_pkg::LSU_LOAD);

   always_comb begin
      fwd_data_dc2   = '0;
      fwd_byteen_dc2 = '0;
      fwd_slot       = rd_ptr;
      for (int i = 0; i < lsu_pkg::LSU_STBUF_DEPTH; i++) begin
         fwd_slot = rd_ptr + i[PB-1:0];
         if (ld_cmp_dc2 && (i < int'(count)) &&
             (entries[fwd_slot].index == stage_dc2.addr[lsu_pkg::LSU_DCCM_ADDR_BITS-1:2])) begin
            for (int b = 0; b < 4; b++) begin
               if (entries[fwd_slot].byteen[b]) begin
                  fwd_byteen_dc2[b]       = 1'b1;
                  fwd_data_dc2[b*8 +: 8] = entries[fwd_slot].data[b*8 +: 8];
               end
            end
         end
      end
      // Committing dc3 store is the youngest
      if (ld_cmp_dc2 && commit_dc3 &&
          (entry_dc3.index == stage_dc2.addr[lsu_pkg::LSU_DCCM_ADDR_BITS-1:2])) begin
         for (int b = 0; b < 4; b++) begin
            if (entry_dc3.byteen[b]) begin
               fwd_byteen_dc2[b]       = 1'b1;
               fwd_data_dc2[b*8 +: 8] = entry_dc3.data[b*8 +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      fwd_data_dc3   <= fwd_data_dc2;
      fwd_byteen_dc3 <= fwd_byteen_dc2;
   end

   //********************
   // Stall when the buffer could not take one more store
   assign st_inflight =
      CW'(stage_dc1.pkt.valid & (stage_dc1.pkt.op == lsu_pkg::LSU_STORE)) +
      CW'(stage_dc2.pkt.valid & (stage_dc2.pkt.op == lsu_pkg::LSU_STORE)) +
      CW'(stage_dc3.pkt.valid & (stage_dc3.pkt.op == lsu_pkg::LSU_STORE));

   assign lsu_store_stall_any = ((CW'(count) + st_inflight) >= CW'(lsu_pkg::LSU_STBUF_DEPTH - 1));

endmodule

`default_nettype wire

// File: hw/lsu_dccm_ctl.sv
//********************
// DCCM read issue and load data path
// Read index goes out in dc2, word returns in dc3
// Forwarded bytes override the DCCM word byte by byte
//********************
`default_nettype none

module lsu_dccm_ctl (
   input  logic                    clk,
   input  logic                    reset,
   input  lsu_pkg::lsu_stage_t     stage_dc2,
   input  lsu_pkg::lsu_stage_t     stage_dc3,
   output logic [7:0]              rd_index,
   input  logic [31:0]             rd_data,
   input  logic [31:0]             fwd_data_dc3,
   input  logic [3:0]              fwd_byteen_dc3,
   input  logic                    flush_dc3,
   output logic [31:0]             lsu_result_dc3,
   output logic                    lsu_load_valid_dc3,
   output lsu_pkg::lsu_error_pkt_t lsu_error_pkt_dc3
);

   logic        ld_rd_dc2;
   logic        ld_rd_dc3;
   logic [31:0] merged_dc3;
   logic [31:0] shifted_dc3;

   //********************
   // Read issue
   assign rd_index  = stage_dc2.addr[lsu_pkg::LSU_DCCM_ADDR_BITS-1:2];
   assign ld_rd_dc2 = stage_dc2.pkt.valid & (stage_dc2.pkt.op == lsu_pkg::LSU_LOAD) &
                      ~stage_dc2.fault;

   // Tracks a good DCCM read into dc3, same kill as the pipe
   always_ff @(posedge clk) begin
      if (reset) begin
         ld_rd_dc3 <= 1'b0;
      end else begin
         ld_rd_dc3 <= ld_rd_dc2 & ~flush_dc3;
      end
   end

   //********************
   // Merge and align
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged_dc3[b*8 +: 8] = fwd_byteen_dc3[b] ? fwd_data_dc3[b*8 +: 8] : rd_data[b*8 +: 8];
      end
   end

   assign shifted_dc3 = merged_dc3 >> {stage_dc3.addr[1:0], 3'b000};   // Addressed lane to bit 0

   always_comb begin
      unique case (stage_dc3.pkt.size)
         lsu_pkg::LSU_BYTE:
            lsu_result_dc3 = {{24{~stage_dc3.pkt.unsign & shifted_dc3[7]}}, shifted_dc3[7:0]};
         lsu_pkg::LSU_HALF:
            lsu_result_dc3 = {{16{~stage_dc3.pkt.unsign & shifted_dc3[15]}}, shifted_dc3[15:0]};
         default:
            lsu_result_dc3 = merged_dc3;
      endcase
   end

   //********************
   // Result strobe and exception
   assign lsu_load_valid_dc3 = ld_rd_dc3 & ~flush_dc3;

   always_comb begin
      lsu_error_pkt_dc3.exc_valid = stage_dc3.pkt.valid & stage_dc3.fault & ~flush_dc3;
      lsu_error_pkt_dc3.is_store  = (stage_dc3.pkt.op == lsu_pkg::LSU_STORE);
      lsu_error_pkt_dc3.cause     = stage_dc3.cause;
      lsu_error_pkt_dc3.addr      = stage_dc3.addr;
   end

endmodule

`default_nettype wire

// File: hw/lsu_dccm_mem.sv
//********************
// DCCM array, one word wide, contents undefined after reset
// Registered read, same word write returns the old data
//********************
`default_nettype none

module lsu_dccm_mem (
   input  logic                  clk,
   input  logic [7:0]            rd_index,
   output logic [31:0]           rd_data,
   input  lsu_pkg::lsu_dccm_wr_t dccm_wr
);

   logic [31:0] mem [lsu_pkg::LSU_DCCM_WORDS];

   // Read port
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_index];
   end

   //********************
   // Byte enabled write port
   always_ff @(posedge clk) begin
      if (dccm_wr.wren) begin
         for (int b = 0; b < 4; b++) begin
            if (dccm_wr.byteen[b]) begin
               mem[dccm_wr.index][b*8 +: 8] <= dccm_wr.data[b*8 +: 8];   // Lane b only
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/lsu.sv
//********************
// Load/store unit top, dc1 -> dc2 -> dc3 (commit)
// DCCM is internal, no bus, no ECC
// Decoder must hold stores while lsu_store_stall_any is high
//********************
`default_nettype none

module lsu (
   input  logic                    clk,
   input  logic                    reset,
   input  lsu_pkg::lsu_pkt_t       lsu_p,
   input  logic [31:0]             rs1,                      // Address base
   input  logic [11:0]             offset,
   input  logic [31:0]             store_data,
   input  logic                    flush_dc3,                // One cycle kill of dc1-dc3
   output logic [31:0]             lsu_result_dc3,
   output logic                    lsu_load_valid_dc3,
   output lsu_pkg::lsu_error_pkt_t lsu_error_pkt_dc3,
   output logic                    lsu_store_stall_any,
   output logic                    lsu_idle_any
);

   lsu_pkg::lsu_stage_t   stage_dc1;
   lsu_pkg::lsu_stage_t   stage_dc2;
   lsu_pkg::lsu_stage_t   stage_dc3;
   lsu_pkg::lsu_dccm_wr_t dccm_wr;
   logic [31:0]           fwd_data_dc3;
   logic [3:0]            fwd_byteen_dc3;
   logic [7:0]            rd_index;
   logic [31:0]           rd_data;
   logic                  stbuf_empty;

   // Nothing in flight and nothing left to drain
   assign lsu_idle_any = ~(stage_dc1.pkt.valid | stage_dc2.pkt.valid | stage_dc3.pkt.valid) &
                         stbuf_empty;

   lsu_lsc_ctl lsc_ctl_i (
      .clk        (clk),
      .reset      (reset),
      .lsu_p      (lsu_p),
      .rs1        (rs1),
      .offset     (offset),
      .store_data (store_data),
      .flush_dc3  (flush_dc3),
      .stage_dc1  (stage_dc1),
      .stage_dc2  (stage_dc2),
      .stage_dc3  (stage_dc3)
   );

   lsu_stbuf stbuf_i (
      .clk                 (clk),
      .reset               (reset),
      .stage_dc1           (stage_dc1),
      .stage_dc2           (stage_dc2),
      .stage_dc3           (stage_dc3),
      .flush_dc3           (flush_dc3),
      .fwd_data_dc3        (fwd_data_dc3),
      .fwd_byteen_dc3      (fwd_byteen_dc3),
      .dccm_wr             (dccm_wr),
      .stbuf_empty         (stbuf_empty),
      .lsu_store_stall_any (lsu_store_stall_any)
   );

   lsu_dccm_ctl dccm_ctl_i (
      .clk                (clk),
      .reset              (reset),
      .stage_dc2          (stage_dc2),
      .stage_dc3          (stage_dc3),
      .rd_index           (rd_index),
      .rd_data            (rd_data),
      .fwd_data_dc3       (fwd_data_dc3),
      .fwd_byteen_dc3     (fwd_byteen_dc3),
      .flush_dc3          (flush_dc3),
      .lsu_result_dc3     (lsu_result_dc3),
      .lsu_load_valid_dc3 (lsu_load_valid_dc3),
      .lsu_error_pkt_dc3  (lsu_error_pkt_dc3)
   );

   lsu_dccm_mem dccm_mem_i (
      .clk      (clk),
      .rd_index (rd_index),
      .rd_data  (rd_data),
      .dccm_wr  (dccm_wr)
   );

endmodule

`default_nettype wire

// File: dv/tb_lsu.sv
//********************
// Testbench for the load/store unit
// Random stimulus from a Galois LFSR, checked against a byte model
// Accesses stay in a 16 word window or fall outside the DCCM
// Inputs change on the falling edge, outputs sampled a quarter period later
// Stops at the first mismatch
//********************
`default_nettype none

module tb_lsu;

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [31:0] SEED      = 32'hffe5_e7c3;
   localparam logic [31:0] TAPS      = 32'ha300_0000;       // Galois feedback mask
   localparam logic [31:0] WIN_BASE  = lsu_pkg::LSU_DCCM_BASE + 32'h100;
   localparam int          WIN_BYTES = 64;                   // 16 words
   localparam int          IDLE_WAIT = 40;
   localparam int          MODE_FILL  = 0;                   // Word stores over the window
   localparam int          MODE_MIX   = 1;                   // Loads, stores, faults, flushes
   localparam int          MODE_HOT   = 2;                   // Two words, heavy forwarding
   localparam int          MODE_BURST = 3;                   // Stores only, throttled by stall
   localparam int          MODE_SWEEP = 4;                   // Word loads over the window
   localparam int          MODE_IDLE  = 5;

   typedef struct packed {
      lsu_pkg::lsu_pkt_t pkt;
      logic [31:0]       addr;
      logic [31:0]       data;
      logic              killed;                             // Hit by a flush
   } tb_instr_t;

   logic                    clk;
   logic                    reset;
   lsu_pkg::lsu_pkt_t       lsu_p;
   logic [31:0]             rs1;
   logic [11:0]             offset;
   logic [31:0]             store_data;
   logic                    flush_dc3;
   logic [31:0]             lsu_result_dc3;
   logic                    lsu_load_valid_dc3;
   lsu_pkg::lsu_error_pkt_t lsu_error_pkt_dc3;
   logic                    lsu_store_stall_any;
   logic                    lsu_idle_any;

   logic [31:0] lfsr;
   logic [7:0]  model_mem [WIN_BYTES];                       // Program order view of the window
   tb_instr_t   in_flight [1:3];                             // Index is stages past the d stage
   int          stbuf_count;                                 // Entries held in the store buffer
   int          word_idx;
   logic        idle_seen;

   lsu lsu_i (
      .clk                 (clk),
      .reset               (reset),
      .lsu_p               (lsu_p),
      .rs1                 (rs1),
      .offset              (offset),
      .store_data          (store_data),
      .flush_dc3           (flush_dc3),
      .lsu_result_dc3      (lsu_result_dc3),
      .lsu_load_valid_dc3  (lsu_load_valid_dc3),
      .lsu_error_pkt_dc3   (lsu_error_pkt_dc3),
      .lsu_store_stall_any (lsu_store_stall_any),
      .lsu_idle_any        (lsu_idle_any)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;                                // 40 ns period
   end

   //********************
   // Random bits, one LFSR step per bit
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] v;
      logic        b;
      v = '0;
      for (int k = 0; k < n; k++) begin
         b    = lfsr[0];
         lfsr = lfsr >> 1;
         if (b) lfsr = lfsr ^ TAPS;
         v = {v[30:0], b};
      end
      return v;
   endfunction

   function automatic logic misaligned(input tb_instr_t t);
      case (t.pkt.size)
         lsu_pkg::LSU_BYTE: return 1'b0;
         lsu_pkg::LSU_HALF: return t.addr[0];
         default:           return t.addr[1:0] != 2'b00;
      endcase
   endfunction

   function automatic logic in_dccm(input logic [31:0] addr);
      return (addr >= lsu_pkg::LSU_DCCM_BASE) &&
             (addr < lsu_pkg::LSU_DCCM_BASE + 32'(lsu_pkg::LSU_DCCM_WORDS * 4));
   endfunction

   // Stores still in dc1-dc3, flushed ones already left the pipe
   function automatic int stores_in_flight();
      int n;
      n = 0;
      for (int s = 1; s <= 3; s++) begin
         if (in_flight[s].pkt.valid && !in_flight[s].killed &&
             (in_flight[s].pkt.op == lsu_pkg::LSU_STORE)) n++;
      end
      return n;
   endfunction

   // Little endian read of the model, extended by size
   function automatic logic [31:0] expected_load(input tb_instr_t t);
      int          off;
      logic [7:0]  b0;
      logic [15:0] h0;
      off = int'(t.addr - WIN_BASE);
      b0  = model_mem[off];
      case (t.pkt.size)
         lsu_pkg::LSU_BYTE:
            return t.pkt.unsign ? {24'h0, b0} : {{24{b0[7]}}, b0};
         lsu_pkg::LSU_HALF: begin
            h0 = {model_mem[off + 1], b0};
            return t.pkt.unsign ? {16'h0, h0} : {{16{h0[15]}}, h0};
         end
         default:
            return {model_mem[off + 3], model_mem[off + 2], model_mem[off + 1], b0};
      endcase
   endfunction

   task automatic commit_store(input tb_instr_t t);
      int off;
      off = int'(t.addr - WIN_BASE);
      model_mem[off] = t.data[7:0];
      if (t.pkt.size != lsu_pkg::LSU_BYTE) model_mem[off + 1] = t.data[15:8];
      if (t.pkt.size == lsu_pkg::LSU_WORD) begin
         model_mem[off + 2] = t.data[23:16];
         model_mem[off + 3] = t.data[31:24];
      end
   endtask

   //********************
   // Compare tasks
   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_load(input logic got_valid, input logic [31:0] got,
                             input logic exp_valid, input logic [31:0] exp);
      if (got_valid !== exp_valid)
         fail_run($sformatf("Error: lsu_load_valid_dc3 got %h expected %h", got_valid, exp_valid));
      else if (exp_valid && (got !== exp))
         fail_run($sformatf("Error: lsu_result_dc3 got %h expected %h", got, exp));
   endtask

   task automatic check_error(input lsu_pkg::lsu_error_pkt_t got,
                              input lsu_pkg::lsu_error_pkt_t exp);
      if ((got.exc_valid !== exp.exc_valid) || (exp.exc_valid && (got !== exp)))
         fail_run($sformatf("Error: lsu_error_pkt_dc3 got %h expected %h", got, exp));
   endtask

   task automatic check_idle(input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("Error: lsu_idle_any got %h expected %h", got, exp));
   endtask

   task automatic check_stall(input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("Error: lsu_store_stall_any got %h expected %h", got, exp));
   endtask

   // Instruction that entered three edges ago is in dc3 now
   task automatic check_dc3(input tb_instr_t t, output logic committed);
      lsu_pkg::lsu_error_pkt_t exp_err;
      logic                    live;
      logic                    fault;
      logic                    exp_ld;
      live  = t.pkt.valid & ~t.killed;
      fault = misaligned(t) | ~in_dccm(t.addr);
      exp_err.exc_valid = live & fault;
      exp_err.is_store  = (t.pkt.op == lsu_pkg::LSU_STORE);
      exp_err.cause     = misaligned(t) ? lsu_pkg::LSU_CAUSE_MISALIGN : lsu_pkg::LSU_CAUSE_ACCESS;
      exp_err.addr      = t.addr;
      exp_ld = live & ~fault & (t.pkt.op == lsu_pkg::LSU_LOAD);
      check_error(lsu_error_pkt_dc3, exp_err);
      if (exp_ld) check_load(lsu_load_valid_dc3, lsu_result_dc3, 1'b1, expected_load(t));
      else        check_load(lsu_load_valid_dc3, lsu_result_dc3, 1'b0, 32'h0);
      committed = live & ~fault & (t.pkt.op == lsu_pkg::LSU_STORE);
      if (committed) commit_store(t);                        // Program order
   endtask

   //********************
   // Stimulus
   function automatic tb_instr_t make_instr(input int mode, input logic stall);
      tb_instr_t   t;
      logic [31:0] r;
      logic [31:0] sz;
      t            = '0;
      t.data       = lfsr_bits(32);
      r            = lfsr_bits(6);                           // Word index and lane
      sz           = lfsr_bits(2);
      t.pkt.valid  = (lfsr_bits(3) != 32'd0);                // About one bubble in eight
      t.pkt.op     = (lfsr_bits(1) != 32'd0) ? lsu_pkg::LSU_STORE : lsu_pkg::LSU_LOAD;
      t.pkt.unsign = (lfsr_bits(1) != 32'd0);
      case (sz[1:0])
         2'b00:   t.pkt.size = lsu_pkg::LSU_BYTE;
         2'b01:   t.pkt.size = lsu_pkg::LSU_HALF;
         default: t.pkt.size = lsu_pkg::LSU_WORD;
      endcase
      if (mode == MODE_HOT) r[5:3] = 3'b000;                 // Words 0 and 1 only
      t.addr = WIN_BASE + {26'h0, r[5:0]};
      if (t.pkt.size == lsu_pkg::LSU_HALF) t.addr[0] = 1'b0;
      if (t.pkt.size == lsu_pkg::LSU_WORD) t.addr[1:0] = 2'b00;
      case (mode)
         MODE_FILL, MODE_SWEEP: begin
            t.pkt.valid = 1'b1;
            t.pkt.op    = (mode == MODE_FILL) ? lsu_pkg::LSU_STORE : lsu_pkg::LSU_LOAD;
            t.pkt.size  = lsu_pkg::LSU_WORD;
            t.addr      = WIN_BASE + 32'(word_idx * 4);
         end
         MODE_BURST: begin
            t.pkt.valid = 1'b1;
            t.pkt.op    = lsu_pkg::LSU_STORE;
         end
         MODE_IDLE: t.pkt.valid = 1'b0;
         MODE_MIX: begin
            if (lfsr_bits(4) == 32'd0) begin                 // Misaligned attempt
               r = lfsr_bits(2);
               t.addr[1:0] = (r[1:0] == 2'b00) ? 2'b10 : r[1:0];
            end
            if (lfsr_bits(4) == 32'd0)                       // Above or below the DCCM
               t.addr = t.addr + ((lfsr_bits(1) != 32'd0) ? 32'h400 : 32'hffff_fe00);
         end
         default: ;
      endcase
      if (stall && (t.pkt.op == lsu_pkg::LSU_STORE)) t.pkt.valid = 1'b0;   // Decoder holds stores
      return t;
   endfunction

   task automatic run_cycle(input int mode);
      tb_instr_t   t;
      logic        flush;
      logic        exp_stall;
      logic        st_commit;
      logic [31:0] r;
      @(negedge clk);
      // Buffer occupancy plus stores in dc1-dc3 against one free slot
      exp_stall = ((stbuf_count + stores_in_flight()) >= (lsu_pkg::LSU_STBUF_DEPTH - 1));
      t     = make_instr(mode, lsu_store_stall_any);
      flush = ((mode == MODE_MIX) || (mode == MODE_HOT)) && (lfsr_bits(5) == 32'd0);
      r     = lfsr_bits(12);
      if (((mode == MODE_FILL) || (mode == MODE_SWEEP)) && t.pkt.valid) word_idx++;
      if (flush) begin
         for (int s = 1; s <= 3; s++) in_flight[s].killed = 1'b1;   // dc1-dc3 die
      end
      lsu_p      = t.pkt;
      offset     = r[11:0];
      rs1        = t.addr - {{20{r[11]}}, r[11:0]};          // Base so the sum hits addr
      store_data = t.data;
      flush_dc3  = flush;
      #10;
      check_dc3(in_flight[3], st_commit);
      check_stall(lsu_store_stall_any, exp_stall);
      if (in_flight[1].pkt.valid) check_idle(lsu_idle_any, 1'b0);
      if (stbuf_count != 0) stbuf_count--;                   // Oldest entry drains at the edge
      if (st_commit) stbuf_count++;
      in_flight[3] = in_flight[2];
      in_flight[2] = in_flight[1];
      in_flight[1] = t;
   endtask

   //********************
   // Test sequence
   initial begin
      lfsr        = SEED;
      word_idx    = 0;
      stbuf_count = 0;
      idle_seen   = 1'b0;
      reset       = 1'b1;
      lsu_p       = '0;
      rs1         = '0;
      offset      = '0;
      store_data  = '0;
      flush_dc3   = 1'b0;
      for (int s = 1; s <= 3; s++) in_flight[s] = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      #10;
      check_idle(lsu_idle_any, 1'b1);

      for (int c = 0; (c < 200) && (word_idx < 16); c++) run_cycle(MODE_FILL);
      if (word_idx < 16) fail_run("Window fill did not finish, stores stayed stalled");
      repeat (400) run_cycle(MODE_MIX);
      repeat (150) run_cycle(MODE_HOT);
      repeat (40) run_cycle(MODE_BURST);
      word_idx = 0;
      for (int c = 0; (c < 64) && (word_idx < 16); c++) run_cycle(MODE_SWEEP);
      if (word_idx < 16) fail_run("Window sweep did not finish");
      repeat (100) run_cycle(MODE_MIX);

      // Pipeline and store buffer must empty
      for (int c = 0; (c < IDLE_WAIT) && !idle_seen; c++) begin
         run_cycle(MODE_IDLE);
         idle_seen = (c >= 3) && (lsu_idle_any === 1'b1);
      end
      if (!idle_seen) begin
         fail_run("Timeout waiting for lsu_idle_any after the last instruction");
      end else begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: files.f
common/lsu_pkg.sv
hw/lsu_lsc_ctl.sv
stbuf/lsu_stbuf.sv
hw/lsu_dccm_ctl.sv
hw/lsu_dccm_mem.sv
hw/lsu.sv
dv/tb_lsu.sv

// File: run.sh
#!/usr/bin/env bash
# Build the LSU testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_lsu \
   -f files.f -o sim_lsu
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_lsu > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi
exit 0
